// File: alloc_pkg.sv
/* heap allocator shared definitions
   word size, address tag constants and the tagged address layout */

package alloc_pkg;

    localparam int DATA_SZ = 16;                        // data and address word width

    localparam logic [3:0]         HEAP_TAG  = 4'h5;    // tag on every valid heap address
    localparam logic [DATA_SZ-1:0] UNDEF     = 16'h0000; // no address, pool exhausted
    localparam logic [DATA_SZ-1:0] FREE_INIT = 16'h5001; // first free before any alloc

    // address word, seen raw or split into its fields
    typedef union packed {
        logic [DATA_SZ-1:0] raw;
        struct packed {
            logic [3:0] tag;                            // must be HEAP_TAG
            logic [3:0] rsvd;                           // must be zero
            logic [7:0] index;                          // cell index into the pool
        } f;
    } alloc_addr_t;

endpackage

// File: alloc_bram.sv
/* simple dual-port block memory
   one write port, one registered read port */

`timescale 1ns/10ps

module alloc_bram import alloc_pkg::*; #(
    parameter int ADDR_SZ = 4                           // log2 of word count
) (
    input  logic               clk,
    input  logic               i_wr_en,
    input  logic [ADDR_SZ-1:0] i_waddr,
    input  logic [DATA_SZ-1:0] i_wdata,
    input  logic               i_rd_en,
    input  logic [ADDR_SZ-1:0] i_raddr,
    output logic [DATA_SZ-1:0] o_rdata,
    output logic               o_rd_valid
);
    localparam int DEPTH = 1 << ADDR_SZ;

    logic [DATA_SZ-1:0] mem [DEPTH];

    // power-up contents, cells read as UNDEF until written
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = UNDEF;
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // registered read, data and valid line up
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rdata <= mem[i_raddr];                    // hold last data between reads
        end
        o_rd_valid <= i_rd_en;
    end

endmodule

// File: alloc_free_list.sv
/* free cell tracker
   bump pointer for fresh cells, stack of freed cells, free address checks */

`timescale 1ns/10ps

module alloc_free_list import alloc_pkg::*; #(
    parameter int ADDR_SZ = 4                           // log2 of pool size, at most 8
) (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_alloc,                 // allocation request
    input  logic               i_free,                  // free request
    input  logic [DATA_SZ-1:0] i_free_addr,             // address to give back
    output logic [ADDR_SZ:0]   o_index,                 // cell for this cycle, msb set if none
    output logic [DATA_SZ-1:0] o_addr,                  // tagged address of last alloc
    output logic               o_err                    // bad request, same cycle
);
    localparam int POOL = 1 << ADDR_SZ;

    logic [ADDR_SZ-1:0] stack [POOL];                   // freed cell indices
    logic [ADDR_SZ:0]   sp;                             // stack depth
    logic [ADDR_SZ:0]   top;                            // depth minus one
    logic [ADDR_SZ:0]   bump;                           // next never-used cell
    alloc_addr_t        free_view;
    alloc_addr_t        new_view;
    logic               free_ok;
    logic               free_acc;
    logic               from_stack;
    logic               exhausted;
    logic               full;
    logic               push;

    assign free_view.raw = i_free_addr;

    // valid heap address of a cell handed out already
    assign free_ok = (free_view.f.tag == HEAP_TAG) &&
                     (free_view.f.rsvd == 4'h0) &&
                     ({1'b0, free_view.f.index} < 9'(bump));
    assign free_acc = i_free && free_ok;

    assign top        = sp - 1'b1;
    assign from_stack = (sp != '0);
    assign full       = sp[ADDR_SZ];                    // depth == POOL

    // cell pick: freed this cycle, then newest freed, then bump
    always_comb begin
        if (free_acc) begin
            o_index = {1'b0, free_view.f.index[ADDR_SZ-1:0]};
        end else if (from_stack) begin
            o_index = {1'b0, stack[top[ADDR_SZ-1:0]]};
        end else begin
            o_index = bump;                             // reads POOL once used up
        end
    end

    assign exhausted = o_index[ADDR_SZ];
    assign o_err     = (i_alloc && exhausted) || (i_free && !free_ok);

    // tagged address for the picked cell
    always_comb begin
        new_view.raw     = '0;
        new_view.f.tag   = HEAP_TAG;
        new_view.f.index = 8'(o_index[ADDR_SZ-1:0]);
    end

    // lone free goes on the stack, alloc+free hands the cell straight over
    assign push = free_acc && !i_alloc && !full;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_addr <= UNDEF;
            sp     <= '0;
            bump   <= '0;
        end else begin
            if (i_alloc) begin
                o_addr <= exhausted ? UNDEF : new_view.raw;
            end
            if (push) begin
                sp <= sp + 1'b1;
            end else if (i_alloc && !exhausted && !free_acc) begin
                if (from_stack) begin
                    sp <= top;                          // pop newest
                end else begin
                    bump <= bump + 1'b1;                // fresh cell
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            stack[sp[ADDR_SZ-1:0]] <= free_view.f.index[ADDR_SZ-1:0];
        end
    end

endmodule

// File: alloc.sv
/* heap cell allocator
   free list plus cell memory, write port arbitration and error merge */

`timescale 1ns/10ps

module alloc import alloc_pkg::*; #(
    parameter int ADDR_SZ = 4                           // log2 of pool size
) (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_alloc,                 // allocate a cell
    input  logic [DATA_SZ-1:0] i_data,                  // word stored in the new cell
    input  logic               i_free,                  // give a cell back
    input  logic [DATA_SZ-1:0] i_addr,                  // tagged address to free
    input  logic               i_wr,                    // plain write strobe
    input  logic [ADDR_SZ-1:0] i_waddr,
    input  logic [DATA_SZ-1:0] i_wdata,
    input  logic               i_rd,                    // plain read strobe
    input  logic [ADDR_SZ-1:0] i_raddr,
    output logic [DATA_SZ-1:0] o_addr,                  // held until next alloc
    output logic [DATA_SZ-1:0] o_rdata,
    output logic               o_rd_valid,
    output logic               o_err                    // one cycle after bad request
);
    logic [ADDR_SZ:0]   cell_index;
    logic               fl_err;
    logic               alloc_wr;
    logic               wr_conflict;
    logic               mem_wr;
    logic [ADDR_SZ-1:0] mem_waddr;
    logic [DATA_SZ-1:0] mem_wdata;

    alloc_free_list #(
        .ADDR_SZ(ADDR_SZ)
    ) u_free_list (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_alloc     (i_alloc),
        .i_free      (i_free),
        .i_free_addr (i_addr),
        .o_index     (cell_index),
        .o_addr      (o_addr),
        .o_err       (fl_err)
    );

    // alloc data write wins the port, none when pool is used up
    assign alloc_wr    = i_alloc && !cell_index[ADDR_SZ];
    assign wr_conflict = alloc_wr && i_wr;              // plain write dropped
    assign mem_wr      = alloc_wr || i_wr;
    assign mem_waddr   = alloc_wr ? cell_index[ADDR_SZ-1:0] : i_waddr;
    assign mem_wdata   = alloc_wr ? i_data : i_wdata;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_err <= 1'b0;
        end else begin
            o_err <= fl_err || wr_conflict;             // one pulse for any source
        end
    end

    alloc_bram #(
        .ADDR_SZ(ADDR_SZ)
    ) u_bram (
        .clk        (clk),
        .i_wr_en    (mem_wr),
        .i_waddr    (mem_waddr),
        .i_wdata    (mem_wdata),
        .i_rd_en    (i_rd),
        .i_raddr    (i_raddr),
        .o_rdata    (o_rdata),
        .o_rd_valid (o_rd_valid)
    );

endmodule

// File: exercise_seq.sv
/* request sequencer
   turns a free-running counter into alloc, free, read and write strobes */

`timescale 1ns/10ps

module exercise_seq import alloc_pkg::*; #(
    parameter int ADDR_SZ  = 4,                         // log2 of pool size
    parameter int CNT_SZ   = 10,                        // counter width
    parameter int PHASE_SZ = 4                          // low bits setting pulse spacing
) (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_enable,                // counter runs while high
    input  logic [DATA_SZ-1:0] i_last_addr,             // allocator result
    output logic               o_alloc,
    output logic [DATA_SZ-1:0] o_alloc_data,
    output logic               o_free,
    output logic [DATA_SZ-1:0] o_free_addr,
    output logic               o_wr,
    output logic [ADDR_SZ-1:0] o_waddr,
    output logic [DATA_SZ-1:0] o_wdata,
    output logic               o_rd,
    output logic [ADDR_SZ-1:0] o_raddr
);
    logic [CNT_SZ-1:0] cnt;
    logic [3:0]        seq;                             // one-cycle request code
    logic              pulse;
    logic              alloc_pend;                      // alloc result lands next cycle

    always_ff @(posedge clk) begin
        if (i_reset) begin
            cnt <= '0;
            seq <= 4'h0;
        end else begin
            if (i_enable) begin
                cnt <= cnt + 1'b1;
            end
            // fire once per phase wrap
            if (i_enable && (&cnt[PHASE_SZ-1:0])) begin
                seq <= cnt[PHASE_SZ+3:PHASE_SZ];
            end else begin
                seq <= 4'h0;
            end
        end
    end

    assign pulse = (seq != 4'h0);

    assign o_alloc      = seq[0];
    assign o_alloc_data = UNDEF;                        // new cells start undefined
    assign o_free       = seq[2];
    assign o_rd         = pulse && (seq[3:2] == 2'b00); // read back at write address
    assign o_wr         = seq[3:2] == 2'b01;
    assign o_raddr      = o_waddr;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_waddr     <= ADDR_SZ'(7);
            o_wdata     <= DATA_SZ'(5);
            o_free_addr <= FREE_INIT;
            alloc_pend  <= 1'b0;
        end else begin
            alloc_pend <= o_alloc;
            if (alloc_pend) begin
                o_free_addr <= i_last_addr;             // free what was just handed out
            end
            if (seq[3:2] == 2'b10) begin
                o_waddr <= o_waddr + ADDR_SZ'(3);       // wraps at pool size
            end
            if (seq[3:2] == 2'b11) begin
                o_wdata <= o_wdata + DATA_SZ'(13);
            end
        end
    end

endmodule

// File: result_monitor.sv
/* read result monitor
   match, sticky error and write address LED levels */

`timescale 1ns/10ps

module result_monitor import alloc_pkg::*; (
    input  logic               clk,
    input  logic               i_reset,
    input  logic [DATA_SZ-1:0] i_rdata,
    input  logic               i_rd_valid,
    input  logic [DATA_SZ-1:0] i_wdata,                 // current write word
    input  logic               i_waddr_lsb,
    input  logic               i_err,
    output logic               o_led_r,                 // any error seen
    output logic               o_led_g,                 // last read matched
    output logic               o_led_b
);
    logic rd_match;

    assign rd_match = (i_rdata == i_wdata);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_led_r <= 1'b0;
            o_led_g <= 1'b0;
        end else begin
            if (i_err) begin
                o_led_r <= 1'b1;                        // stays until reset
            end
            if (i_rd_valid) begin
                o_led_g <= rd_match;                    // held between reads
            end
        end
    end

    assign o_led_b = i_waddr_lsb;

endmodule

// File: alloc_top.sv
/* allocator exerciser top level
   sequencer drives the allocator, monitor shows the results on LEDs */

`timescale 1ns/10ps

module alloc_top import alloc_pkg::*; #(
    parameter int ADDR_SZ  = 4,                         // 16 cell pool
    parameter int CNT_SZ   = 10,
    parameter int PHASE_SZ = 4                          // request every 16 enabled cycles
) (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_enable,
    output logic [DATA_SZ-1:0] o_addr,
    output logic               o_err,
    output logic [DATA_SZ-1:0] o_rdata,
    output logic               o_rd_valid,
    output logic               o_led_r,
    output logic               o_led_g,
    output logic               o_led_b
);
    logic               alloc_stb;
    logic [DATA_SZ-1:0] alloc_data;
    logic               free_stb;
    logic [DATA_SZ-1:0] free_addr;
    logic               wr_stb;
    logic [ADDR_SZ-1:0] waddr;
    logic [DATA_SZ-1:0] wdata;
    logic               rd_stb;
    logic [ADDR_SZ-1:0] raddr;

    exercise_seq #(
        .ADDR_SZ  (ADDR_SZ),
        .CNT_SZ   (CNT_SZ),
        .PHASE_SZ (PHASE_SZ)
    ) u_seq (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_enable     (i_enable),
        .i_last_addr  (o_addr),                         // most recent alloc fed back
        .o_alloc      (alloc_stb),
        .o_alloc_data (alloc_data),
        .o_free       (free_stb),
        .o_free_addr  (free_addr),
        .o_wr         (wr_stb),
        .o_waddr      (waddr),
        .o_wdata      (wdata),
        .o_rd         (rd_stb),
        .o_raddr      (raddr)
    );

    alloc #(
        .ADDR_SZ(ADDR_SZ)
    ) u_alloc (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_alloc    (alloc_stb),
        .i_data     (alloc_data),
        .i_free     (free_stb),
        .i_addr     (free_addr),
        .i_wr       (wr_stb),
        .i_waddr    (waddr),
        .i_wdata    (wdata),
        .i_rd       (rd_stb),
        .i_raddr    (raddr),
        .o_addr     (o_addr),
        .o_rdata    (o_rdata),
        .o_rd_valid (o_rd_valid),
        .o_err      (o_err)
    );

    result_monitor u_mon (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_rdata     (o_rdata),
        .i_rd_valid  (o_rd_valid),
        .i_wdata     (wdata),
        .i_waddr_lsb (waddr[0]),
        .i_err       (o_err),
        .o_led_r     (o_led_r),
        .o_led_g     (o_led_g),
        .o_led_b     (o_led_b)
    );

endmodule

// File: tb_alloc_top.sv
/* allocator exerciser testbench
   cycle model of sequencer, free list, memory and LEDs checked on every clock */

`timescale 1ns/10ps

module tb_alloc_top import alloc_pkg::*; ();

    localparam int ADDR_SZ      = 4;
    localparam int CNT_SZ       = 10;
    localparam int PHASE_SZ     = 4;
    localparam int POOL         = 1 << ADDR_SZ;
    localparam int RESET_CYCLES = 10;
    localparam int RUN_ENABLED  = 3 * (1 << CNT_SZ);    // three counter wraps
    // enable is high 3 of 4 cycles, so the run needs about 4/3 of that
    localparam int TIMEOUT_CYCLES = 4 * (RESET_CYCLES + RUN_ENABLED * 4 / 3);

    logic               clk;
    logic               i_reset;
    logic               i_enable;
    logic [DATA_SZ-1:0] o_addr;
    logic               o_err;
    logic [DATA_SZ-1:0] o_rdata;
    logic               o_rd_valid;
    logic               o_led_r;
    logic               o_led_g;
    logic               o_led_b;

    // model state
    logic [CNT_SZ-1:0]  cnt_q;
    logic [3:0]         seq_q;
    logic [ADDR_SZ-1:0] waddr_q;
    logic [DATA_SZ-1:0] wdata_q;
    logic [DATA_SZ-1:0] free_addr_q;
    logic               alloc_pend_q;                   // last cycle allocated
    int                 sp_q;                           // freed cells on stack
    int                 bump_q;                         // next fresh cell
    int                 stack_q [POOL];
    logic [DATA_SZ-1:0] mem_q [POOL] = '{default: UNDEF}; // power-up contents
    logic [DATA_SZ-1:0] exp_addr;
    logic               exp_err;
    logic [DATA_SZ-1:0] exp_rdata;
    logic               exp_rd_valid;
    logic               exp_led_r;
    logic               exp_led_g;

    int   n_checks  = 0;
    int   n_errors  = 0;
    int   n_reads   = 0;
    logic timed_out = 1'b0;

    alloc_top #(
        .ADDR_SZ  (ADDR_SZ),
        .CNT_SZ   (CNT_SZ),
        .PHASE_SZ (PHASE_SZ)
    ) u_alloc_top (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_enable   (i_enable),
        .o_addr     (o_addr),
        .o_err      (o_err),
        .o_rdata    (o_rdata),
        .o_rd_valid (o_rd_valid),
        .o_led_r    (o_led_r),
        .o_led_g    (o_led_g),
        .o_led_b    (o_led_b)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                          // 8 ns period
    end

    // one clock edge of the whole system, all next values from current ones
    function automatic void ref_step(input logic rst, input logic en);
        logic [3:0] seq_c;
        logic       alloc_c;
        logic       free_c;
        logic       rd_c;
        logic       wr_c;
        logic       free_ok;
        logic       free_acc;
        logic       exhausted;
        int         fidx;
        int         pick;
        if (rst) begin
            cnt_q        = '0;
            seq_q        = 4'h0;
            waddr_q      = ADDR_SZ'(7);
            wdata_q      = DATA_SZ'(5);
            free_addr_q  = FREE_INIT;
            alloc_pend_q = 1'b0;
            sp_q         = 0;
            bump_q       = 0;
            exp_addr     = UNDEF;
            exp_err      = 1'b0;
            exp_rd_valid = 1'b0;
            exp_led_r    = 1'b0;
            exp_led_g    = 1'b0;
            return;
        end
        seq_c   = seq_q;
        alloc_c = seq_c[0];
        free_c  = seq_c[2];
        rd_c    = (seq_c != 4'h0) && (seq_c[3:2] == 2'b00);
        wr_c    = (seq_c[3:2] == 2'b01);
        // free accepted only for a tagged address of a cell handed out
        fidx     = int'(free_addr_q[ADDR_SZ-1:0]);
        free_ok  = (free_addr_q[15:12] == HEAP_TAG) && (free_addr_q[11:8] == 4'h0) &&
                   (int'(free_addr_q[7:0]) < bump_q);
        free_acc = free_c && free_ok;
        if (free_acc) begin
            pick = fidx;                                // handed straight over
        end else if (sp_q > 0) begin
            pick = stack_q[sp_q - 1];                   // newest freed first
        end else begin
            pick = bump_q;
        end
        exhausted = (pick >= POOL);

        // LEDs see the registered read and error of the last edge
        if (exp_err) exp_led_r = 1'b1;
        if (exp_rd_valid) exp_led_g = (exp_rdata == wdata_q);
        if (alloc_pend_q) free_addr_q = exp_addr;       // free the latest alloc
        alloc_pend_q = alloc_c;

        // read sees memory before this edge's write
        if (rd_c) exp_rdata = mem_q[waddr_q];
        exp_rd_valid = rd_c;
        if (alloc_c && !exhausted) begin
            mem_q[pick] = UNDEF;                        // alloc data wins the port
        end else if (wr_c) begin
            mem_q[waddr_q] = wdata_q;
        end

        exp_err = (alloc_c && exhausted) || (free_c && !free_ok) ||
                  (alloc_c && !exhausted && wr_c);
        if (alloc_c) exp_addr = exhausted ? UNDEF : {HEAP_TAG, 4'h0, 8'(pick)};
        if (free_acc && !alloc_c) begin
            if (sp_q < POOL) begin
                stack_q[sp_q] = fidx;
                sp_q++;
            end
        end else if (alloc_c && !exhausted && !free_acc) begin
            if (sp_q > 0) sp_q--;
            else bump_q++;
        end

        if (seq_c[3:2] == 2'b10) waddr_q = waddr_q + ADDR_SZ'(3); // wraps at pool
        if (seq_c[3:2] == 2'b11) wdata_q = wdata_q + DATA_SZ'(13);
        if (en && (&cnt_q[PHASE_SZ-1:0])) seq_q = cnt_q[PHASE_SZ+3:PHASE_SZ];
        else seq_q = 4'h0;
        if (en) cnt_q = cnt_q + CNT_SZ'(1);
    endfunction

    task automatic check_val(input string name, input logic [DATA_SZ-1:0] actual,
                             input logic [DATA_SZ-1:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("Mismatch at time %0t: %s is %h, expected %h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic end_run();
        $display("checks %0d  reads %0d  errors %0d", n_checks, n_reads, n_errors);
        if (n_errors == 0 && n_reads != 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    // model steps on the edge, DUT outputs compared once settled
    always @(posedge clk) begin : compare
        logic in_reset;
        in_reset = i_reset;
        ref_step(i_reset, i_enable);
        #1;
        if (!in_reset) begin
            check_val("o_addr", o_addr, exp_addr);
            check_val("o_err", DATA_SZ'(o_err), DATA_SZ'(exp_err));
            check_val("o_rd_valid", DATA_SZ'(o_rd_valid), DATA_SZ'(exp_rd_valid));
            if (exp_rd_valid) begin
                check_val("o_rdata", o_rdata, exp_rdata);
                n_reads++;
            end
            check_val("o_led_r", DATA_SZ'(o_led_r), DATA_SZ'(exp_led_r));
            check_val("o_led_g", DATA_SZ'(o_led_g), DATA_SZ'(exp_led_g));
            check_val("o_led_b", DATA_SZ'(o_led_b), DATA_SZ'(waddr_q[0]));
        end
    end

    initial begin : stimulus
        int driven;
        driven   = 0;
        i_reset  = 1'b1;
        i_enable = 1'b0;
        void'($urandom(87));
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;
        while (driven < RUN_ENABLED) begin
            @(negedge clk);
            i_enable = ($urandom % 4) != 0;             // paused about 1 cycle in 4
            if (i_enable) driven++;
        end
        @(negedge clk);
        i_enable = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        if (n_reads == 0) $display("the DUT returned no read data during the run");
        end_run();
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        timed_out = 1'b1;
        $display("run timed out after %0d cycles", cycles);
        end_run();
    end

endmodule

// File: filelist.f
alloc_pkg.sv
alloc_bram.sv
alloc_free_list.sv
alloc.sv
exercise_seq.sv
result_monitor.sv
alloc_top.sv
tb_alloc_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the allocator testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f filelist.f --top-module tb_alloc_top \
    || { echo "build failed"; exit 1; }
out="$(./obj_dir/Vtb_alloc_top)"
echo "$out"
grep -qx "All checks passed" <<< "$out" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
